//--- int_exu_params.svh
`ifndef INT_EXU_PARAMS_SVH
`define INT_EXU_PARAMS_SVH

// ========================================
// datapath widths
// ========================================
`define XLEN        64          // rv64 integer word.

// ========================================
// register file and tags
// ========================================
`define PRF_DEPTH   64          // physical integer registers.
`define PRF_IDX_W   6           // log2 of PRF_DEPTH.

`define ROB_IDX_W   6           // global rob tag.
`define IROB_IDX_W  4           // integer rob tag.

`endif

//--- int_exu_pkg.sv
`include "int_exu_params.svh"

package int_exu_pkg;

    // ========================================
    // basic vector types
    // ========================================
    typedef logic [`XLEN-1:0]       xlen_t;
    typedef logic [`PRF_IDX_W-1:0]  iprf_idx_t;   // preg 0 always reads zero.
    typedef logic [`ROB_IDX_W-1:0]  rob_idx_t;
    typedef logic [`IROB_IDX_W-1:0] irob_idx_t;

    typedef enum logic [3:0] {
        lui, add, sub, addw, subw,
        sll, srl, sra, sllw, srlw, sraw,
        op_xor, op_or, op_and,
        slt, sltu
    } mic_op_t;

    // ========================================
    // stage records
    // ========================================
    typedef struct packed {
        mic_op_t   mic_op;
        iprf_idx_t rs1;
        iprf_idx_t rs2;
        logic      use_imm;
        xlen_t     imm;          // already sign extended.
        iprf_idx_t rd;
        logic      rd_wen;
        rob_idx_t  rob_idx;
        irob_idx_t irob_idx;
    } issue_info_t;

    typedef struct packed {
        mic_op_t   mic_op;
        xlen_t     src0;
        xlen_t     src1;         // imm when the op uses one.
        iprf_idx_t rd;
        logic      rd_wen;
        rob_idx_t  rob_idx;
        irob_idx_t irob_idx;
    } fu_info_t;

    typedef struct packed {
        rob_idx_t  rob_idx;
        irob_idx_t irob_idx;
        logic      rd_wen;
        iprf_idx_t rd;
        xlen_t     result;
    } val_wb_info_t;

endpackage

//--- int_prf.sv
`timescale 1ns/1ps
`include "int_exu_params.svh"

module int_prf
    import int_exu_pkg::*;
(
    input  logic      clk,
    input  logic      rst,

    // read ports
    input  iprf_idx_t i_rd_idx0,
    input  iprf_idx_t i_rd_idx1,
    output xlen_t     o_rd_data0,
    output xlen_t     o_rd_data1,

    // write port
    input  logic      i_wr_en,
    input  iprf_idx_t i_wr_idx,
    input  xlen_t     i_wr_data
);

    xlen_t regs [`PRF_DEPTH];

    // ========================================
    // write port
    // ========================================
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `PRF_DEPTH; i++) begin
                regs[i] <= '0;
            end
        end
        else if (i_wr_en && (i_wr_idx != '0)) begin   // preg 0 never changes.
            regs[i_wr_idx] <= i_wr_data;
        end
    end

    // ========================================
    // read ports
    // ========================================
    // a same-cycle write is not forwarded.
    // the writeback bypass in the operand
    // reader covers that case.
    always_comb begin
        if (i_rd_idx0 == '0) begin
            o_rd_data0 = '0;
        end
        else begin
            o_rd_data0 = regs[i_rd_idx0];
        end
        if (i_rd_idx1 == '0) begin
            o_rd_data1 = '0;
        end
        else begin
            o_rd_data1 = regs[i_rd_idx1];
        end
    end

endmodule

//--- int_operand_read.sv
`timescale 1ns/1ps

module int_operand_read
    import int_exu_pkg::*;
(
    // issue side
    input  logic         i_issue_vld,
    input  issue_info_t  i_issue_info,
    input  logic         i_stall,

    // bypass from the alu input stage
    input  logic         i_willwrite_vld,
    input  iprf_idx_t    i_willwrite_idx,
    input  xlen_t        i_willwrite_data,

    // bypass from the writeback stage
    input  logic         i_wb_vld,
    input  val_wb_info_t i_wb_info,

    // register file
    output iprf_idx_t    o_rd_idx0,
    output iprf_idx_t    o_rd_idx1,
    input  xlen_t        i_rd_data0,
    input  xlen_t        i_rd_data1,

    // to the alu
    output logic         o_fu_vld,
    output fu_info_t     o_fu_info
);

    // ========================================
    // source resolution
    // ========================================
    // zero reg first, then the op in the alu,
    // then the op in writeback, then whatever
    // the prf already holds.
    function automatic xlen_t pick_src(
        input iprf_idx_t idx,
        input xlen_t     prf_data
    );
        xlen_t val;
        if (idx == '0) begin
            val = '0;
        end
        else if (i_willwrite_vld && (i_willwrite_idx == idx)) begin
            val = i_willwrite_data;                    // result computed this cycle.
        end
        else if (i_wb_vld && i_wb_info.rd_wen && (i_wb_info.rd == idx)) begin
            val = i_wb_info.result;                    // not yet in the prf.
        end
        else begin
            val = prf_data;
        end
        return val;
    endfunction

    assign o_rd_idx0 = i_issue_info.rs1;
    assign o_rd_idx1 = i_issue_info.rs2;

    xlen_t src0;
    xlen_t src1;

    always_comb begin
        src0 = pick_src(i_issue_info.rs1, i_rd_data0);
        if (i_issue_info.use_imm) begin
            src1 = i_issue_info.imm;
        end
        else begin
            src1 = pick_src(i_issue_info.rs2, i_rd_data1);
        end
    end

    // ========================================
    // alu input record
    // ========================================
    always_comb begin
        o_fu_info.mic_op   = i_issue_info.mic_op;
        o_fu_info.src0     = src0;
        o_fu_info.src1     = src1;
        o_fu_info.rd       = i_issue_info.rd;
        o_fu_info.rd_wen   = i_issue_info.rd_wen;
        o_fu_info.rob_idx  = i_issue_info.rob_idx;
        o_fu_info.irob_idx = i_issue_info.irob_idx;
    end

    assign o_fu_vld = i_issue_vld && !i_stall;   // nothing is taken while stalled.

endmodule

//--- alu.sv
`timescale 1ns/1ps

module alu
    import int_exu_pkg::*;
(
    input  logic         clk,
    input  logic         rst,

    output logic         o_fu_stall,
    input  logic         i_vld,
    input  fu_info_t     i_fu_info,

    // bypass export from the input stage
    output logic         o_willwrite_vld,
    output iprf_idx_t    o_willwrite_rd_idx,
    output xlen_t        o_willwrite_data,

    // writeback
    input  logic         i_wb_stall,
    output logic         o_wb_vld,
    output val_wb_info_t o_wb_info
);

    // ========================================
    // input stage
    // ========================================
    logic     ex_vld;
    fu_info_t ex_info;

    always_ff @(posedge clk) begin
        if (rst) begin
            ex_vld        <= 1'b0;
            ex_info.rd_wen <= 1'b0;
        end
        else if (!i_wb_stall) begin
            ex_vld  <= i_vld;
            ex_info <= i_fu_info;
        end
    end

    // ========================================
    // execute
    // ========================================
    xlen_t       src0;
    xlen_t       src1;
    xlen_t       result;
    logic [5:0]  shamt;
    logic [4:0]  shamt_w;
    logic [31:0] word;                      // low half for the w forms.

    assign src0    = ex_info.src0;
    assign src1    = ex_info.src1;
    assign shamt   = src1[5:0];
    assign shamt_w = src1[4:0];

    always_comb begin
        word   = '0;
        result = '0;
        case (ex_info.mic_op)
            lui:    result = src1;          // issue already shifted and extended it.
            add:    result = src0 + src1;
            sub:    result = src0 - src1;
            sll:    result = src0 << shamt;
            srl:    result = src0 >> shamt;
            sra:    result = xlen_t'($signed(src0) >>> shamt);
            op_xor: result = src0 ^ src1;
            op_or:  result = src0 | src1;
            op_and: result = src0 & src1;
            slt:    result = xlen_t'($signed(src0) < $signed(src1));
            sltu:   result = xlen_t'(src0 < src1);
            addw, subw, sllw, srlw, sraw: begin
                case (ex_info.mic_op)
                    addw:    word = src0[31:0] + src1[31:0];
                    subw:    word = src0[31:0] - src1[31:0];
                    sllw:    word = src0[31:0] << shamt_w;
                    srlw:    word = src0[31:0] >> shamt_w;
                    default: word = 32'($signed(src0[31:0]) >>> shamt_w);
                endcase
                result = {{32{word[31]}}, word};
            end
            default: result = '0;
        endcase
    end

    // ========================================
    // writeback stage
    // ========================================
    logic         wb_vld;
    val_wb_info_t wb_info;

    always_ff @(posedge clk) begin
        if (rst) begin
            wb_vld         <= 1'b0;
            wb_info.rd_wen <= 1'b0;
        end
        else if (!i_wb_stall) begin     // record holds until delivered.
            wb_vld           <= ex_vld;
            wb_info.rob_idx  <= ex_info.rob_idx;
            wb_info.irob_idx <= ex_info.irob_idx;
            wb_info.rd_wen   <= ex_info.rd_wen;
            wb_info.rd       <= ex_info.rd;
            wb_info.result   <= result;
        end
    end

    assign o_willwrite_vld    = ex_vld && ex_info.rd_wen;
    assign o_willwrite_rd_idx = ex_info.rd;
    assign o_willwrite_data   = result;

    assign o_fu_stall = i_wb_stall;
    assign o_wb_vld   = wb_vld;
    assign o_wb_info  = wb_info;

endmodule

//--- int_exu_top.sv
`timescale 1ns/1ps

module int_exu_top
    import int_exu_pkg::*;
(
    input  logic         clk,
    input  logic         rst,

    input  logic         i_issue_vld,
    input  issue_info_t  i_issue_info,
    output logic         o_issue_stall,

    input  logic         i_wb_stall,
    output logic         o_wb_vld,
    output val_wb_info_t o_wb_info
);

    logic      fu_vld;
    fu_info_t  fu_info;
    logic      willwrite_vld;
    iprf_idx_t willwrite_idx;
    xlen_t     willwrite_data;
    iprf_idx_t rd_idx0;
    iprf_idx_t rd_idx1;
    xlen_t     rd_data0;
    xlen_t     rd_data1;
    logic      prf_wr_en;

    // ========================================
    // operand read
    // ========================================
    int_operand_read int_operand_read_i (
        .i_issue_vld      (i_issue_vld),
        .i_issue_info     (i_issue_info),
        .i_stall          (o_issue_stall),
        .i_willwrite_vld  (willwrite_vld),
        .i_willwrite_idx  (willwrite_idx),
        .i_willwrite_data (willwrite_data),
        .i_wb_vld         (o_wb_vld),
        .i_wb_info        (o_wb_info),
        .o_rd_idx0        (rd_idx0),
        .o_rd_idx1        (rd_idx1),
        .i_rd_data0       (rd_data0),
        .i_rd_data1       (rd_data1),
        .o_fu_vld         (fu_vld),
        .o_fu_info        (fu_info)
    );

    // a record retires into the prf on the edge it is delivered.
    assign prf_wr_en = o_wb_vld && o_wb_info.rd_wen && !i_wb_stall;

    int_prf int_prf_i (
        .clk        (clk),
        .rst        (rst),
        .i_rd_idx0  (rd_idx0),
        .i_rd_idx1  (rd_idx1),
        .o_rd_data0 (rd_data0),
        .o_rd_data1 (rd_data1),
        .i_wr_en    (prf_wr_en),
        .i_wr_idx   (o_wb_info.rd),
        .i_wr_data  (o_wb_info.result)
    );

    // ========================================
    // execute
    // ========================================
    alu alu_i (
        .clk                (clk),
        .rst                (rst),
        .o_fu_stall         (o_issue_stall),
        .i_vld              (fu_vld),
        .i_fu_info          (fu_info),
        .o_willwrite_vld    (willwrite_vld),
        .o_willwrite_rd_idx (willwrite_idx),
        .o_willwrite_data   (willwrite_data),
        .i_wb_stall         (i_wb_stall),
        .o_wb_vld           (o_wb_vld),
        .o_wb_info          (o_wb_info)
    );

endmodule

//--- int_exu_checker.sv
`timescale 1ns/1ps

module int_exu_checker
    import int_exu_pkg::*;
(
    input logic         clk,
    input logic         rst,
    input logic         i_issue_vld,
    input logic         o_issue_stall,
    input logic         i_wb_stall,
    input logic         o_wb_vld,
    input val_wb_info_t o_wb_info
);

    // ========================================
    // writeback protocol
    // ========================================
    a_wb_hold: assert property (@(posedge clk) disable iff (rst)
        (o_wb_vld && i_wb_stall) |=> (o_wb_vld && $stable(o_wb_info)))
        else $error("writeback record changed while stalled");

    a_reset_idle: assert property (@(posedge clk)
        ($past(rst) && !rst) |-> !o_wb_vld)
        else $error("writeback valid right after reset");

    // accept at E, free edge at E+1, valid seen at E+2.
    a_latency: assert property (@(posedge clk) disable iff (rst)
        ($past(i_issue_vld && !o_issue_stall, 2) && !$past(i_wb_stall, 1)
            && !$past(rst, 2) && !$past(rst, 1)) |-> o_wb_vld)
        else $error("accepted op missing on writeback after two cycles");

endmodule

bind int_exu_top int_exu_checker int_exu_checker_i (
    .clk          (clk),
    .rst          (rst),
    .i_issue_vld  (i_issue_vld),
    .o_issue_stall(o_issue_stall),
    .i_wb_stall   (i_wb_stall),
    .o_wb_vld     (o_wb_vld),
    .o_wb_info    (o_wb_info)
);

//--- int_exu_tb.sv
`timescale 1ns/1ps
`include "int_exu_params.svh"

module int_exu_tb
    import int_exu_pkg::*;
;
    logic         clk;
    logic         rst;
    logic         i_issue_vld;
    logic         o_issue_stall;
    logic         i_wb_stall;
    logic         o_wb_vld;
    logic         stall_rand;
    issue_info_t  i_issue_info;
    val_wb_info_t o_wb_info;
    val_wb_info_t exp_q [$];
    xlen_t        mregs [`PRF_DEPTH];      // shadow register file.
    integer       seed;
    int           cyc;
    int           last_wb_cyc;
    int           last_acc_cyc;
    string        cur_test;
    rob_idx_t     rob_cnt;
    irob_idx_t    irob_cnt;

    int_exu_top int_exu_top_i (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("Done: errors found");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check(input string name, input logic [127:0] exp, input logic [127:0] act);
        if (exp !== act) begin
            $display("ERROR %s: expected %h, actual %h", name, exp, act);
            fail_run("value mismatch");
        end
    endtask

    function automatic xlen_t sext32(input logic [31:0] w);
        return {{32{w[31]}}, w};
    endfunction

    // expected result straight from the isa rules.
    function automatic xlen_t alu_model(input mic_op_t op, input xlen_t a, input xlen_t b);
        logic [31:0] w;
        case (op)
            lui:     return b;
            add:     return a + b;
            sub:     return a - b;
            addw:    return sext32(a[31:0] + b[31:0]);
            subw:    return sext32(a[31:0] - b[31:0]);
            sll:     return a << b[5:0];
            srl:     return a >> b[5:0];
            sra:     return $signed(a) >>> b[5:0];
            sllw: begin
                w = a[31:0] << b[4:0];
                return sext32(w);
            end
            srlw: begin
                w = a[31:0] >> b[4:0];
                return sext32(w);
            end
            sraw: begin
                w = $signed(a[31:0]) >>> b[4:0];
                return sext32(w);
            end
            op_xor:  return a ^ b;
            op_or:   return a | b;
            op_and:  return a & b;
            slt:     return ($signed(a) < $signed(b)) ? 64'd1 : 64'd0;
            default: return (a < b) ? 64'd1 : 64'd0;
        endcase
    endfunction

    function automatic xlen_t rand64();
        return {$random(seed), $random(seed)};
    endfunction

    function automatic iprf_idx_t rand_reg();          // one of p1..p20.
        return iprf_idx_t'(1 + ($unsigned($random(seed)) % 20));
    endfunction

    function automatic issue_info_t make_op(input mic_op_t op, input iprf_idx_t rs1,
                                            input iprf_idx_t rs2, input logic use_imm,
                                            input xlen_t imm, input iprf_idx_t rd);
        issue_info_t u;
        u = '{op, rs1, rs2, use_imm, imm, rd, 1'b1, rob_cnt, irob_cnt};
        rob_cnt++;
        irob_cnt++;
        return u;
    endfunction

    task automatic issue_op(input issue_info_t u);
        int t;
        xlen_t a, b, res;
        i_issue_vld  <= 1'b1;
        i_issue_info <= u;
        for (t = 0; t < 200; t++) begin
            @(posedge clk);
            if (!o_issue_stall) break;
        end
        if (t == 200) fail_run("micro-op was never accepted");
        last_acc_cyc = cyc;
        a = mregs[u.rs1];
        b = u.use_imm ? u.imm : mregs[u.rs2];
        res = alu_model(u.mic_op, a, b);
        if (u.rd_wen && u.rd != '0) mregs[u.rd] = res;
        exp_q.push_back(val_wb_info_t'{u.rob_idx, u.irob_idx, u.rd_wen, u.rd, res});
    endtask

    task automatic drain();
        int t;
        i_issue_vld <= 1'b0;
        for (t = 0; t < 500 && exp_q.size() != 0; t++) @(posedge clk);
        if (exp_q.size() != 0) fail_run("no writeback arrived before the timeout");
        repeat (3) @(posedge clk);                    // catch any extra record.
    endtask

    // ========================================
    // writeback monitor and stall source
    // ========================================
    always @(posedge clk) begin
        cyc <= cyc + 1;
        check(cur_test, i_wb_stall, o_issue_stall);      // issue stall follows the wb stall.
        if (!rst && o_wb_vld && !i_wb_stall) begin
            if (exp_q.size() == 0) fail_run("writeback arrived with nothing outstanding");
            check(cur_test, exp_q.pop_front(), o_wb_info);
            last_wb_cyc = cyc;
        end
        i_wb_stall <= stall_rand ? (($random(seed) & 3) == 0) : 1'b0;
    end

    // ========================================
    // directed tests
    // ========================================
    task automatic test_reset();
        cur_test = "test_reset";
        repeat (4) begin
            @(posedge clk);
            check(cur_test, 0, o_wb_vld);
        end
        for (int r = 1; r < 6; r++) issue_op(make_op(add, iprf_idx_t'(r), '0, 1'b1, '0,
                                                      iprf_idx_t'(r)));
        drain();
    endtask

    task automatic test_each_op();
        xlen_t v, sh [4];
        cur_test = "test_each_op";
        sh = '{64'd0, 64'd31, 64'd32, 64'd63};
        for (int r = 1; r <= 20; r++) begin
            v = rand64();
            issue_op(make_op(lui, '0, '0, 1'b1, sext32({v[31:12], 12'h0}), iprf_idx_t'(r)));
            issue_op(make_op(add, iprf_idx_t'(r), '0, 1'b1, xlen_t'($signed(v[11:0])),
                             iprf_idx_t'(r)));
        end
        for (int k = 0; k < 16; k++) begin
            for (int j = 0; j < 6; j++) begin
                v = (j < 4) ? sh[j] : rand64();            // fixed shift amounts first.
                issue_op(make_op(mic_op_t'(k), rand_reg(), rand_reg(), (j < 4) || (k == 0),
                                 v, rand_reg()));
            end
        end
        drain();
    endtask

    task automatic test_bypass();
        int first;
        cur_test = "test_bypass";
        for (int d = 1; d <= 3; d++) begin
            for (int k = 0; k < 12; k++) begin
                issue_op(make_op((k % 2) ? op_xor : add, iprf_idx_t'(21 + k % d), rand_reg(),
                                 1'b0, '0, iprf_idx_t'(21 + k % d)));
                if (k == 0) first = last_acc_cyc;
            end
            drain();
            check(cur_test, first + 13, last_wb_cyc);     // no bubbles in the chain.
        end
    endtask

    task automatic test_stall();
        cur_test = "test_stall";
        stall_rand <= 1'b1;
        for (int k = 0; k < 40; k++) begin
            issue_op(make_op(mic_op_t'($random(seed) & 15), rand_reg(), rand_reg(),
                             k[0], rand64(), rand_reg()));
        end
        stall_rand <= 1'b0;
        drain();
    endtask

    task automatic test_reg_zero();
        cur_test = "test_reg_zero";
        issue_op(make_op(add, 5, '0, 1'b1, 64'd7, '0));
        issue_op(make_op(add, '0, '0, 1'b0, '0, 3));     // reads p0 right behind the write.
        issue_op(make_op(op_or, '0, '0, 1'b1, 64'd0, '0));
        issue_op(make_op(sub, 4, '0, 1'b0, '0, 6));
        drain();
    endtask

    task automatic test_tags();
        issue_info_t u;
        cur_test = "test_tags";
        for (int k = 0; k < 16; k++) begin
            u = make_op(mic_op_t'($random(seed) & 15), rand_reg(), rand_reg(), 1'b0, '0,
                        rand_reg());
            u.rob_idx  = rob_idx_t'($random(seed));
            u.irob_idx = irob_idx_t'($random(seed));
            issue_op(u);
        end
        drain();
    endtask

    initial begin
        seed         = 32'h1eea_cff3;
        rst          = 1'b1;
        i_issue_vld  = 1'b0;
        i_issue_info = '0;
        i_wb_stall   = 1'b0;
        stall_rand   = 1'b0;
        cyc          = 0;
        rob_cnt      = '0;
        irob_cnt     = '0;
        cur_test     = "reset";
        for (int i = 0; i < `PRF_DEPTH; i++) mregs[i] = '0;
        repeat (16) @(posedge clk);
        rst <= 1'b0;
        test_reset();
        test_each_op();
        test_bypass();
        test_stall();
        test_reg_zero();
        test_tags();
        $display("Done: no errors");
        $finish;
    end

endmodule

//--- all.f
+incdir+.
int_exu_pkg.sv
int_prf.sv
int_operand_read.sv
alu.sv
int_exu_top.sv
int_exu_checker.sv
int_exu_tb.sv

//--- run.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --assert -j 0 -f all.f --top-module int_exu_tb -o sim_int_exu

# the simulator exit status is checked through the log below.
./obj_dir/sim_int_exu > sim.log 2>&1 || true
cat sim.log

if grep -q "Done: no errors" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi
